// ==== filelist.f ====
+incdir+dv
logic/regm_pkg.sv
logic/reg_slot.sv
logic/operand_select.sv
logic/issue_ctrl.sv
logic/reg_manage.sv
dv/tb_reg_manage.sv

// ==== Bender.yml ====
package:
  name: reg_manage

sources:
  - files:
      - logic/regm_pkg.sv
      - logic/reg_slot.sv
      - logic/operand_select.sv
      - logic/issue_ctrl.sv
      - logic/reg_manage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_reg_manage.sv

// ==== dv/reg_manage_tests.svh ====
`ifndef REG_MANAGE_TESTS_SVH
`define REG_MANAGE_TESTS_SVH

// fill some registers, then read them back through issue
task automatic test_write_read();
    word_t v;
    for (int r = 1; r <= 6; r++) begin
        v = $random(seed);
        write_reg(reg_addr_t'(r), v);
    end
    present(make_inst(5'd1, 5'd2, 5'd12, 4'b0000));
    complete(0, 1'b1);
    write_reg(5'd12, $random(seed));
    // register 0 as a source
    present(make_inst(5'd3, 5'd0, 5'd0, 4'b0000));
    complete(0, 1'b1);
    present(make_inst(5'd0, 5'd6, 5'd0, 4'b0000));
    complete(0, 1'b1);
    present(make_inst(5'd4, 5'd5, 5'd13, 4'b0100));
    complete(0, 1'b1);
    write_reg(5'd13, $random(seed));
endtask

task automatic test_raw_forward();
    word_t v;
    present(make_inst(5'd1, 5'd2, 5'd5, 4'b0000));
    complete(0, 1'b1);
    present(make_inst(5'd5, 5'd3, 5'd0, 4'b0000));
    observe_cycles(3);
    // result arrives while the reader waits
    v = $random(seed);
    drive_wb(5'd5, v);
    complete(0, 1'b1);
endtask

task automatic test_waw_stall();
    present(make_inst(5'd0, 5'd0, 5'd7, 4'b0000));
    complete(0, 1'b1);
    present(make_inst(5'd1, 5'd2, 5'd7, 4'b0000));
    observe_cycles(3);
    drive_wb(5'd7, $random(seed));
    complete(0, 1'b1);
    // second claim on r7 is open here, rd 0 goes through anyway
    present(make_inst(5'd1, 5'd0, 5'd0, 4'b0000));
    complete(0, 1'b1);
    present(make_inst(5'd0, 5'd2, 5'd0, 4'b0000));
    complete(0, 1'b1);
    write_reg(5'd7, $random(seed));
endtask

task automatic test_credits();
    for (int k = 0; k < ISSUE_CREDITS; k++) begin
        present(make_inst(reg_addr_t'(k + 1), 5'd0, 5'd0, 4'b0000));
        complete(0, 1'b0);
    end
    // execute full, decode has to wait
    present(make_inst(5'd2, 5'd3, 5'd0, 4'b0000));
    observe_cycles(5);
    return_credit();
    complete(0, 1'b0);
    present(make_inst(5'd4, 5'd1, 5'd0, 4'b0000));
    observe_cycles(3);
    return_credit();
    complete(0, 1'b0);
    for (int k = 0; k < ISSUE_CREDITS; k++) begin
        return_credit();
    end
endtask

task automatic test_branch_flush();
    word_t v;
    write_reg(5'd8, $random(seed));
    present(make_inst(5'd1, 5'd0, 5'd8, 4'b0001));
    complete(0, 1'b1);
    present(make_inst(5'd2, 5'd0, 5'd9, 4'b0010));
    complete(0, 1'b1);
    // squash candidate arrives together with the flush
    @(posedge clk);
    clear_pulses();
    order       <= 1'b1;
    inst        <= make_inst(5'd0, 5'd0, 5'd11, 4'b0001);
    cur_inst    = make_inst(5'd0, 5'd0, 5'd11, 4'b0001);
    flush_valid <= 1'b1;
    flush_ctx   <= 4'b0001;
    model_flush(4'b0001);
    @(negedge clk);
    check_flag(done, 1'b1, "done on a squashed instruction");
    check_flag(squashed, 1'b1, "squashed under an overlapping flush");
    @(posedge clk);
    clear_pulses();
    order <= 1'b0;
    @(negedge clk);
    check_flag(issue_valid, 1'b0, "issue_valid after a squash");
    // r8 was flushed and r11 never claimed
    present(make_inst(5'd8, 5'd11, 5'd0, 4'b0000));
    complete(0, 1'b1);
    present(make_inst(5'd9, 5'd0, 5'd0, 4'b0000));
    observe_cycles(3);
    v = $random(seed);
    drive_wb(5'd9, v);
    complete(0, 1'b1);
endtask

`endif

// ==== dv/tb_reg_manage.sv ====
`timescale 1ns/100ps

module tb_reg_manage;

    import regm_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         order;
    inst_t        inst;
    logic         done;
    logic         squashed;
    logic         issue_valid;
    issue_t       issue;
    logic         credit_return;
    logic         wb_valid;
    wb_t          wb;
    logic         flush_valid;
    ctx_t         flush_ctx;

    // reference model of the register file
    word_t                model_regs [NUM_REGS];
    logic [NUM_REGS-1:0]  model_pending;
    ctx_t                 model_ctx [NUM_REGS];
    int                   model_credits;

    inst_t   cur_inst;
    integer  seed = 26;

    reg_manage i_reg_manage (
        .clk           (clk),
        .rst_n         (rst_n),
        .order         (order),
        .inst          (inst),
        .done          (done),
        .squashed      (squashed),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .credit_return (credit_return),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .flush_valid   (flush_valid),
        .flush_ctx     (flush_ctx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_issue(input issue_t got, input issue_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    function automatic inst_t make_inst(input reg_addr_t rs1, input reg_addr_t rs2,
                                        input reg_addr_t rd, input ctx_t ctx);
        inst_t in;
        in.rs1 = rs1;
        in.rs2 = rs2;
        in.rd  = rd;
        in.ctx = ctx;
        return in;
    endfunction

    // model updates follow the writeback, claim and flush rules
    function automatic void model_wb(input reg_addr_t addr, input word_t data);
        if (addr != '0) begin
            model_regs[addr]    = data;
            model_pending[addr] = 1'b0;
        end
    endfunction

    function automatic void model_claim(input inst_t in);
        if (in.rd != '0) begin
            model_pending[in.rd] = 1'b1;
            model_ctx[in.rd]     = in.ctx;
        end
    endfunction

    function automatic void model_flush(input ctx_t fctx);
        for (int i = 0; i < NUM_REGS; i++) begin
            if (model_pending[i] && (|(model_ctx[i] & fctx))) begin
                model_pending[i] = 1'b0;
            end
        end
    endfunction

    // hazard check with no writeback or flush in the cycle
    function automatic logic model_can_issue(input inst_t in);
        logic src_ok;
        src_ok = !model_pending[in.rs1] && !model_pending[in.rs2];
        return src_ok && !model_pending[in.rd] && (model_credits > 0);
    endfunction

    function automatic issue_t expect_issue(input inst_t in);
        issue_t e;
        e.rs1_data = model_regs[in.rs1];
        e.rs2_data = model_regs[in.rs2];
        e.rd       = in.rd;
        e.ctx      = in.ctx;
        return e;
    endfunction

    task automatic clear_pulses();
        wb_valid      <= 1'b0;
        flush_valid   <= 1'b0;
        credit_return <= 1'b0;
    endtask

    // writeback lands in the cycle after this edge
    task automatic drive_wb(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        clear_pulses();
        wb_valid <= 1'b1;
        wb.rd    <= addr;
        wb.data  <= data;
        model_wb(addr, data);
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        drive_wb(addr, data);
        @(posedge clk);
        clear_pulses();
    endtask

    task automatic return_credit();
        @(posedge clk);
        clear_pulses();
        credit_return <= 1'b1;
        @(posedge clk);
        clear_pulses();
        model_credits++;
    endtask

    task automatic present(input inst_t in);
        @(posedge clk);
        clear_pulses();
        order    <= 1'b1;
        inst     <= in;
        cur_inst = in;
    endtask

    task automatic observe_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_flag(done, model_can_issue(cur_inst), "done while hazard is open");
        end
    endtask

    // wait for done, then check the bundle one cycle later
    task automatic complete(input int max_cycles, input logic ret);
        int     cycles;
        issue_t exp;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            if (cycles >= max_cycles) begin
                fail_run("timeout: done never rose for the presented instruction");
            end
            cycles++;
            @(negedge clk);
        end
        check_flag(squashed, 1'b0, "squashed on a normal issue");
        check_flag(issue_valid, 1'b0, "issue_valid in the done cycle");
        exp = expect_issue(cur_inst);
        model_claim(cur_inst);
        model_credits--;
        @(posedge clk);
        clear_pulses();
        order         <= 1'b0;
        credit_return <= ret;
        if (ret) begin
            model_credits++;
        end
        @(negedge clk);
        check_flag(issue_valid, 1'b1, "issue_valid after done");
        check_issue(issue, exp, "issue bundle");
    endtask

    `include "reg_manage_tests.svh"

    initial begin
        rst_n         = 1'b0;
        order         = 1'b0;
        inst          = '0;
        credit_return = 1'b0;
        wb_valid      = 1'b0;
        wb            = '0;
        flush_valid   = 1'b0;
        flush_ctx     = '0;
        cur_inst      = '0;
        model_pending = '0;
        model_credits = ISSUE_CREDITS;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
            model_ctx[i]  = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_write_read();
        test_raw_forward();
        test_waw_stall();
        test_credits();
        test_branch_flush();
        @(posedge clk);
        clear_pulses();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== logic/reg_manage.sv ====
`timescale 1ns/100ps

module reg_manage (
    input  logic              clk,
    input  logic              rst_n,

    // decode
    input  logic              order,
    input  regm_pkg::inst_t   inst,
    output logic              done,
    output logic              squashed,

    // execute
    output logic              issue_valid,
    output regm_pkg::issue_t  issue,
    input  logic              credit_return,

    // writeback
    input  logic              wb_valid,
    input  regm_pkg::wb_t     wb,

    // branch hazard
    input  logic              flush_valid,
    input  regm_pkg::ctx_t    flush_ctx
);

    import regm_pkg::*;

    word_t                slot_data [NUM_REGS];
    logic [NUM_REGS-1:0]  slot_pending;
    ctx_t                 slot_ctx [NUM_REGS];

    word_t   rs1_data;
    word_t   rs2_data;
    logic    rs1_ready;
    logic    rs2_ready;
    logic    claim_valid;
    claim_t  claim;

    // register file, one slot per architectural register
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_slot
        reg_slot #(
            .SLOT_INDEX (i)
        ) i_reg_slot (
            .clk         (clk),
            .rst_n       (rst_n),
            .wb_valid    (wb_valid),
            .wb          (wb),
            .claim_valid (claim_valid),
            .claim       (claim),
            .flush_valid (flush_valid),
            .flush_ctx   (flush_ctx),
            .data        (slot_data[i]),
            .pending     (slot_pending[i]),
            .ctx         (slot_ctx[i])
        );
    end

    operand_select i_operand_select (
        .inst         (inst),
        .slot_data    (slot_data),
        .slot_pending (slot_pending),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_ready    (rs1_ready),
        .rs2_ready    (rs2_ready)
    );

    issue_ctrl i_issue_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .order         (order),
        .inst          (inst),
        .done          (done),
        .squashed      (squashed),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rs1_ready     (rs1_ready),
        .rs2_ready     (rs2_ready),
        .slot_pending  (slot_pending),
        .slot_ctx      (slot_ctx),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .flush_valid   (flush_valid),
        .flush_ctx     (flush_ctx),
        .credit_return (credit_return),
        .claim_valid   (claim_valid),
        .claim         (claim),
        .issue_valid   (issue_valid),
        .issue         (issue)
    );

endmodule

// ==== logic/issue_ctrl.sv ====
`timescale 1ns/100ps

module issue_ctrl (
    input  logic              clk,
    input  logic              rst_n,

    // decode handshake
    input  logic              order,
    input  regm_pkg::inst_t   inst,
    output logic              done,
    output logic              squashed,

    // operands from operand_select
    input  regm_pkg::word_t   rs1_data,
    input  regm_pkg::word_t   rs2_data,
    input  logic              rs1_ready,
    input  logic              rs2_ready,

    // slot state
    input  logic [regm_pkg::NUM_REGS-1:0] slot_pending,
    input  regm_pkg::ctx_t    slot_ctx [regm_pkg::NUM_REGS],

    input  logic              wb_valid,
    input  regm_pkg::wb_t     wb,
    input  logic              flush_valid,
    input  regm_pkg::ctx_t    flush_ctx,

    // execute side flow control
    input  logic              credit_return,

    // destination reservation to the slots
    output logic              claim_valid,
    output regm_pkg::claim_t  claim,

    // bundle toward execute
    output logic              issue_valid,
    output regm_pkg::issue_t  issue
);

    import regm_pkg::*;

    credit_cnt_t credits;
    logic        rd_zero;
    logic        rd_fwd;
    logic        rd_flush_hit;
    logic        rd_ready;
    logic        have_credit;
    logic        accept;

    // squash only looks at the context, hazards do not matter
    assign squashed = order && flush_valid && (|(inst.ctx & flush_ctx));

    assign rd_zero = (inst.rd == '0);
    assign rd_fwd  = wb_valid && (wb.rd == inst.rd);

    // pending destination being cleared by this flush
    assign rd_flush_hit = slot_pending[inst.rd]
                        && flush_valid
                        && (|(slot_ctx[inst.rd] & flush_ctx));

    // a flushed slot is only trusted again next cycle
    assign rd_ready = rd_zero
                    || !slot_pending[inst.rd]
                    || (rd_fwd && !rd_flush_hit);

    assign have_credit = (credits != '0);

    assign accept = order
                  && !squashed
                  && rs1_ready
                  && rs2_ready
                  && rd_ready
                  && have_credit;

    assign done = squashed || accept;

    // reserve the destination in the done cycle
    assign claim_valid = accept && !rd_zero;
    assign claim.rd    = inst.rd;
    assign claim.ctx   = inst.ctx;

    // acceptance and return may coincide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_cnt_t'(ISSUE_CREDITS);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    // payload, qualified by issue_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.rs1_data <= rs1_data;
            issue.rs2_data <= rs2_data;
            issue.rd       <= inst.rd;
            issue.ctx      <= inst.ctx;
        end
    end

endmodule

// ==== logic/operand_select.sv ====
`timescale 1ns/100ps

module operand_select (
    input  regm_pkg::inst_t  inst,

    // register file contents
    input  regm_pkg::word_t  slot_data [regm_pkg::NUM_REGS],
    input  logic [regm_pkg::NUM_REGS-1:0] slot_pending,

    // same-cycle writeback for forwarding
    input  logic             wb_valid,
    input  regm_pkg::wb_t    wb,

    output regm_pkg::word_t  rs1_data,
    output regm_pkg::word_t  rs2_data,
    output logic             rs1_ready,
    output logic             rs2_ready
);

    import regm_pkg::*;

    reg_addr_t src_addr  [2];
    word_t     src_data  [2];
    logic      src_ready [2];
    logic      src_fwd   [2];

    assign src_addr[0] = inst.rs1;
    assign src_addr[1] = inst.rs2;

    // both sources resolved the same way
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_fwd[s] = wb_valid
                       && (wb.rd == src_addr[s])
                       && (src_addr[s] != '0);

            if (src_addr[s] == '0) begin
                src_data[s] = '0;
            end else if (src_fwd[s]) begin
                src_data[s] = wb.data;
            end else begin
                src_data[s] = slot_data[src_addr[s]];
            end

            // forwarded value makes a pending source usable now
            src_ready[s] = (src_addr[s] == '0)
                         || !slot_pending[src_addr[s]]
                         || src_fwd[s];
        end
    end

    assign rs1_data  = src_data[0];
    assign rs2_data  = src_data[1];
    assign rs1_ready = src_ready[0];
    assign rs2_ready = src_ready[1];

endmodule

// ==== logic/reg_slot.sv ====
`timescale 1ns/100ps

module reg_slot #(
    parameter int SLOT_INDEX = 0
) (
    input  logic              clk,
    input  logic              rst_n,

    // writeback from execute
    input  logic              wb_valid,
    input  regm_pkg::wb_t     wb,

    // destination reservation from issue control
    input  logic              claim_valid,
    input  regm_pkg::claim_t  claim,

    // branch hazard
    input  logic              flush_valid,
    input  regm_pkg::ctx_t    flush_ctx,

    // slot state
    output regm_pkg::word_t   data,
    output logic              pending,
    output regm_pkg::ctx_t    ctx
);

    import regm_pkg::*;

    logic wb_hit;
    logic claim_hit;
    logic flush_hit;
    logic writable;

    // register 0 reads zero forever
    assign writable = (SLOT_INDEX != 0);

    assign wb_hit = wb_valid
                  && (wb.rd == reg_addr_t'(SLOT_INDEX))
                  && writable;

    assign claim_hit = claim_valid
                     && (claim.rd == reg_addr_t'(SLOT_INDEX))
                     && writable;

    // only a pending slot under an overlapping branch is cleared
    assign flush_hit = flush_valid && pending && (|(ctx & flush_ctx));

    // data only changes on writeback, a flush keeps the last value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data <= '0;
        end else if (wb_hit) begin
            data <= wb.data;
        end
    end

    // a claim wins over a writeback or flush in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            ctx     <= '0;
        end else if (claim_hit) begin
            pending <= 1'b1;
            ctx     <= claim.ctx;
        end else if (wb_hit || flush_hit) begin
            pending <= 1'b0;
            ctx     <= '0;
        end
    end

endmodule

// ==== logic/regm_pkg.sv ====
package regm_pkg;

    // data path widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CTX_W      = 4;

    // architectural register count, register 0 hardwired to zero
    localparam int NUM_REGS = 32;

    // bundles execute can hold before it must return a credit
    localparam int ISSUE_CREDITS = 4;
    localparam int CREDIT_W      = 3;

    // register data word
    typedef logic [WORD_W-1:0] word_t;

    // register file index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // one bit per unresolved branch
    typedef logic [CTX_W-1:0] ctx_t;

    // credit counter, holds 0 to ISSUE_CREDITS
    typedef logic [CREDIT_W-1:0] credit_cnt_t;

    // request from decode
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        ctx_t      ctx;
    } inst_t;

    // result coming back from execute
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // destination reservation
    typedef struct packed {
        reg_addr_t rd;
        ctx_t      ctx;
    } claim_t;

    // operands and destination handed to execute
    typedef struct packed {
        word_t     rs1_data;
        word_t     rs2_data;
        reg_addr_t rd;
        ctx_t      ctx;
    } issue_t;

endpackage
